/* Bender.yml */
package:
  name: wb_stage

sources:
  - files:
      - wb_pkg.sv
      - wb_hold_buf.sv
      - wb_arbiter.sv
      - regfile.sv
      - commit_tracker.sv
      - wb_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - wb_top_properties.sv
      - tb_wb_top.sv

/* commit_tracker.sv */
// pending bitmap of issued but uncommitted instruction tags
`timescale 1ns/1ps
`default_nettype none

module commit_tracker (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   issue_valid_i,
    input  wire  [wb_pkg::COMMIT_ID_WIDTH-1:0]    issue_id_i,
    input  wb_pkg::wb_req_t                       commit_i,
    output logic [wb_pkg::NUM_COMMIT_IDS-1:0]     pending_o
);

    import wb_pkg::*;

    logic [NUM_COMMIT_IDS-1:0] pending_q;
    logic [NUM_COMMIT_IDS-1:0] set_mask;
    logic [NUM_COMMIT_IDS-1:0] clr_mask;

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (issue_valid_i) begin
            set_mask[issue_id_i] = 1'b1;
        end
        if (commit_i.we) begin
            clr_mask[commit_i.commit_id] = 1'b1;
        end
    end

    // set applied after clear, so an issue beats a same-cycle commit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clr_mask) | set_mask;
        end
    end

    assign pending_o = pending_q;

endmodule

`default_nettype wire

/* regfile.sv */
// 32x32 register file, one write port, two combinational read ports
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wb_pkg::wb_req_t                     wr_i,
    input  wire  [wb_pkg::REG_ADDR_WIDTH-1:0]   raddr_a_i,
    input  wire  [wb_pkg::REG_ADDR_WIDTH-1:0]   raddr_b_i,
    output logic [wb_pkg::REG_DATA_WIDTH-1:0]   rdata_a_o,
    output logic [wb_pkg::REG_DATA_WIDTH-1:0]   rdata_b_o
);

    import wb_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

    // x0 has no storage
    logic [REG_DATA_WIDTH-1:0] regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.waddr != '0)) begin
            regs_q[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // no bypass, a write shows up the cycle after it is taken
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // falling edge at 1 ns starts the async reset
    initial begin
        rst_n_o = 1'b1;
        #1 rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb_wb_top.sv */
// testbench top for the writeback stage with directed and random traffic
`timescale 1ns/1ps
`default_nettype none

module tb_wb_top;

    import wb_pkg::*;

    localparam int          RAND_CYCLES = 400;
    localparam int          WAIT_LIMIT  = 100;
    localparam int          BURST_LEN   = 12;
    localparam logic [31:0] LCG_MUL     = 32'd1664525;
    localparam logic [31:0] LCG_INC     = 32'd1013904223;
    localparam logic [31:0] SEED        = 32'd86;

    logic                      clk;
    logic                      rst_n;
    wb_req_t                   lsu_req;
    wb_req_t                   mul_req;
    wb_req_t                   div_req;
    wb_req_t                   csr_req;
    wb_req_t                   alu_req;
    logic                      mul_ready;
    logic                      div_ready;
    logic                      csr_ready;
    logic                      alu_ready;
    logic                      issue_valid;
    logic [COMMIT_ID_WIDTH-1:0] issue_id;
    logic [REG_ADDR_WIDTH-1:0] raddr_a;
    logic [REG_ADDR_WIDTH-1:0] raddr_b;
    wb_req_t                   wb;
    logic                      commit_valid;
    logic [COMMIT_ID_WIDTH-1:0] commit_id;
    logic [REG_DATA_WIDTH-1:0] rdata_a;
    logic [REG_DATA_WIDTH-1:0] rdata_b;
    logic [NUM_COMMIT_IDS-1:0] pending;
    logic [31:0]               lcg_state;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    wb_top u_dut (
        .clk (clk), .rst_n (rst_n),
        .lsu_req_i (lsu_req), .mul_req_i (mul_req), .div_req_i (div_req),
        .csr_req_i (csr_req), .alu_req_i (alu_req),
        .mul_ready_o (mul_ready), .div_ready_o (div_ready),
        .csr_ready_o (csr_ready), .alu_ready_o (alu_ready),
        .issue_valid_i (issue_valid), .issue_id_i (issue_id),
        .raddr_a_i (raddr_a), .raddr_b_i (raddr_b),
        .wb_o (wb), .commit_valid_o (commit_valid), .commit_id_o (commit_id),
        .rdata_a_o (rdata_a), .rdata_b_o (rdata_b), .pending_o (pending)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * LCG_MUL + LCG_INC;
        return lcg_state;
    endfunction

    function automatic wb_req_t random_req(input logic we);
        wb_req_t     r;
        logic [31:0] a;
        a = next_rand();
        r.we        = we;
        r.waddr     = a[20:16];
        r.commit_id = a[30:28];
        r.wdata     = next_rand();
        return r;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping the run");
    endtask

    task automatic idle_sources();
        lsu_req     <= '0;
        mul_req     <= '0;
        div_req     <= '0;
        csr_req     <= '0;
        alu_req     <= '0;
        issue_valid <= 1'b0;
    endtask

    // reset is already asserted at the first edge
    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_run("timeout: reset was never released");
        end while (!rst_n);
    endtask

    // one idle cycle at least, then all readys high
    task automatic wait_drained();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_run("timeout: hold buffers did not drain");
        end while (!(mul_ready && div_ready && csr_ready && alu_ready));
    endtask

    // readys seen here belong to the cycle that just ended
    task automatic drive_random();
        logic [31:0] r;
        r = next_rand();
        lsu_req     <= random_req(r[31:29] == 3'd0);
        mul_req     <= random_req(r[28] && mul_ready);
        div_req     <= random_req(r[27] && div_ready);
        csr_req     <= random_req(r[26] && csr_ready);
        alu_req     <= random_req(r[25] && alu_ready);
        issue_valid <= r[24];
        issue_id    <= r[23:21];
    endtask

    // read back the last written register, port b walks all addresses
    always @(posedge clk) begin
        raddr_a <= wb.we ? wb.waddr : raddr_a;
        raddr_b <= raddr_b + 1'b1;
    end

    always @(posedge clk) begin
        if (u_dut.u_props.err_cnt != 0) begin
            fail_run("an assertion on the writeback stage failed");
        end
    end

    initial begin
        lcg_state   = SEED;
        lsu_req     = '0;
        mul_req     = '0;
        div_req     = '0;
        csr_req     = '0;
        alu_req     = '0;
        issue_valid = 1'b0;
        issue_id    = '0;
        raddr_a     = '0;
        raddr_b     = '0;
        wait_reset_release();
        wait_drained();

        // all five sources in the same cycle
        lsu_req <= random_req(1'b1);
        mul_req <= random_req(1'b1);
        div_req <= random_req(1'b1);
        csr_req <= random_req(1'b1);
        alu_req <= random_req(1'b1);
        @(posedge clk);
        idle_sources();
        wait_drained();

        // lsu burst starves the parked requests
        lsu_req <= random_req(1'b1);
        mul_req <= random_req(1'b1);
        div_req <= random_req(1'b1);
        csr_req <= random_req(1'b1);
        alu_req <= random_req(1'b1);
        repeat (BURST_LEN) begin
            @(posedge clk);
            idle_sources();
            lsu_req <= random_req(1'b1);
        end
        @(posedge clk);
        idle_sources();
        wait_drained();

        repeat (RAND_CYCLES) begin
            drive_random();
            @(posedge clk);
        end
        idle_sources();
        wait_drained();
        repeat (3) @(posedge clk);

        if (u_dut.u_props.err_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("assertion failures were counted");
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
wb_pkg.sv
wb_hold_buf.sv
wb_arbiter.sv
regfile.sv
commit_tracker.sv
wb_top.sv
tb_clock_gen.sv
wb_top_properties.sv
tb_wb_top.sv

/* wb_arbiter.sv */
// writeback arbiter with fixed priority, hold buffers and a registered winner
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  wire              clk,
    input  wire              rst_n,
    input  wb_pkg::wb_req_t  lsu_req_i,
    input  wb_pkg::wb_req_t  mul_req_i,
    input  wb_pkg::wb_req_t  div_req_i,
    input  wb_pkg::wb_req_t  csr_req_i,
    input  wb_pkg::wb_req_t  alu_req_i,
    output logic             mul_ready_o,
    output logic             div_ready_o,
    output logic             csr_ready_o,
    output logic             alu_ready_o,
    output wb_pkg::wb_req_t  wb_o
);

    import wb_pkg::*;

    localparam int REQ_W = $bits(wb_req_t);

    // all per-source vectors are indexed by wb_src_e
    wb_req_t             req  [NUM_SRCS];
    wb_req_t             held [NUM_SRCS];
    logic [NUM_SRCS-1:0] full;
    logic [NUM_SRCS-1:0] active;
    logic [NUM_SRCS-1:0] conflict;
    logic [NUM_SRCS-1:0] buf_block;
    logic [NUM_SRCS-1:0] gnt_new;
    logic [NUM_SRCS-1:0] gnt_buf;
    logic [NUM_SRCS-1:0] capture;
    logic                any_full;
    wb_req_t             win;
    wb_req_t             wb_q;

    assign req[SRC_LSU] = lsu_req_i;
    assign req[SRC_MUL] = mul_req_i;
    assign req[SRC_DIV] = div_req_i;
    assign req[SRC_CSR] = csr_req_i;
    assign req[SRC_ALU] = alu_req_i;

    // lsu has no buffer
    assign held[SRC_LSU] = '0;
    assign full[SRC_LSU] = 1'b0;

    for (genvar i = int'(SRC_MUL); i < NUM_SRCS; i++) begin : g_hold
        wb_hold_buf u_hold_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .capture_i (capture[i]),
            .req_i     (req[i]),
            .grant_i   (gnt_buf[i]),
            .held_o    (held[i]),
            .full_o    (full[i])
        );
    end

    // accepted fresh requests, a full buffer stalls its source
    assign active   = {req[SRC_ALU].we, req[SRC_CSR].we, req[SRC_DIV].we,
                       req[SRC_MUL].we, req[SRC_LSU].we} & ~full;
    assign any_full = |full;

    // fresh requests lose to lsu, any parked request and higher fresh ones
    assign conflict[SRC_LSU]  = 1'b0;
    assign conflict[SRC_MUL]  = active[SRC_LSU] | any_full;
    // buffers lose to lsu and higher buffers
    assign buf_block[SRC_LSU] = 1'b1;
    assign buf_block[SRC_MUL] = active[SRC_LSU];

    for (genvar i = int'(SRC_DIV); i < NUM_SRCS; i++) begin : g_chain
        assign conflict[i]  = conflict[i-1] | active[i-1];
        assign buf_block[i] = buf_block[i-1] | full[i-1];
    end

    // one-hot over gnt_new and gnt_buf together
    assign gnt_new = active & ~conflict;
    assign gnt_buf = full & ~buf_block;
    assign capture = active & conflict;

    // and-or select of the winner
    always_comb begin
        win = '0;
        for (int i = 0; i < NUM_SRCS; i++) begin
            win = win | ({REQ_W{gnt_new[i]}} & req[i]) | ({REQ_W{gnt_buf[i]}} & held[i]);
        end
        win.we = |{gnt_new, gnt_buf};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= win;
        end
    end

    assign wb_o = wb_q;

    assign mul_ready_o = ~full[SRC_MUL];
    assign div_ready_o = ~full[SRC_DIV];
    assign csr_ready_o = ~full[SRC_CSR];
    assign alu_ready_o = ~full[SRC_ALU];

endmodule

`default_nettype wire

/* wb_hold_buf.sv */
// one-entry parking buffer for a writeback request that lost arbitration
`timescale 1ns/1ps
`default_nettype none

module wb_hold_buf (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              capture_i,
    input  wb_pkg::wb_req_t  req_i,
    input  wire              grant_i,
    output wb_pkg::wb_req_t  held_o,
    output logic             full_o
);

    import wb_pkg::*;

    logic    valid_q;
    wb_req_t data_q;

    // capture only happens while empty, grant only while full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (capture_i) begin
            valid_q <= 1'b1;
        end else if (grant_i) begin
            valid_q <= 1'b0;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (capture_i) begin
            data_q <= req_i;
        end
    end

    always_comb begin
        held_o    = data_q;
        held_o.we = valid_q;
    end

    assign full_o = valid_q;

endmodule

`default_nettype wire

/* wb_pkg.sv */
// writeback widths, request struct and source enumeration
`default_nettype none

package wb_pkg;

    // register file geometry
    localparam int REG_DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // in-flight instruction tags
    localparam int COMMIT_ID_WIDTH = 3;
    localparam int NUM_COMMIT_IDS  = 2 ** COMMIT_ID_WIDTH;

    // lsu plus the four buffered units
    localparam int NUM_SRCS = 5;

    // one writeback request, we doubles as the valid strobe
    typedef struct packed {
        logic                       we;
        logic [REG_ADDR_WIDTH-1:0]  waddr;
        logic [REG_DATA_WIDTH-1:0]  wdata;
        logic [COMMIT_ID_WIDTH-1:0] commit_id;
    } wb_req_t;

    // writeback sources in priority order
    typedef enum logic [2:0] {
        SRC_LSU = 3'd0,
        SRC_MUL = 3'd1,
        SRC_DIV = 3'd2,
        SRC_CSR = 3'd3,
        SRC_ALU = 3'd4
    } wb_src_e;

endpackage

`default_nettype wire

/* wb_top.sv */
// writeback stage top: arbiter, register file and commit tracker
`timescale 1ns/1ps
`default_nettype none

module wb_top (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wb_pkg::wb_req_t                      lsu_req_i,
    input  wb_pkg::wb_req_t                      mul_req_i,
    input  wb_pkg::wb_req_t                      div_req_i,
    input  wb_pkg::wb_req_t                      csr_req_i,
    input  wb_pkg::wb_req_t                      alu_req_i,
    output logic                                 mul_ready_o,
    output logic                                 div_ready_o,
    output logic                                 csr_ready_o,
    output logic                                 alu_ready_o,
    input  wire                                  issue_valid_i,
    input  wire  [wb_pkg::COMMIT_ID_WIDTH-1:0]   issue_id_i,
    input  wire  [wb_pkg::REG_ADDR_WIDTH-1:0]    raddr_a_i,
    input  wire  [wb_pkg::REG_ADDR_WIDTH-1:0]    raddr_b_i,
    output wb_pkg::wb_req_t                      wb_o,
    output logic                                 commit_valid_o,
    output logic [wb_pkg::COMMIT_ID_WIDTH-1:0]   commit_id_o,
    output logic [wb_pkg::REG_DATA_WIDTH-1:0]    rdata_a_o,
    output logic [wb_pkg::REG_DATA_WIDTH-1:0]    rdata_b_o,
    output logic [wb_pkg::NUM_COMMIT_IDS-1:0]    pending_o
);

    import wb_pkg::*;

    // registered winner, feeds all three consumers
    wb_req_t wb;

    wb_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .lsu_req_i   (lsu_req_i),
        .mul_req_i   (mul_req_i),
        .div_req_i   (div_req_i),
        .csr_req_i   (csr_req_i),
        .alu_req_i   (alu_req_i),
        .mul_ready_o (mul_ready_o),
        .div_ready_o (div_ready_o),
        .csr_ready_o (csr_ready_o),
        .alu_ready_o (alu_ready_o),
        .wb_o        (wb)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (wb),
        .raddr_a_i (raddr_a_i),
        .raddr_b_i (raddr_b_i),
        .rdata_a_o (rdata_a_o),
        .rdata_b_o (rdata_b_o)
    );

    commit_tracker u_commit_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid_i (issue_valid_i),
        .issue_id_i    (issue_id_i),
        .commit_i      (wb),
        .pending_o     (pending_o)
    );

    assign wb_o           = wb;
    assign commit_valid_o = wb.we;
    assign commit_id_o    = wb.commit_id;

endmodule

`default_nettype wire

/* wb_top_properties.sv */
// concurrent checks on the writeback stage and their bind to wb_top
`timescale 1ns/1ps
`default_nettype none

module wb_top_properties (
    input wire                                 clk,
    input wire                                 rst_n,
    input wire wb_pkg::wb_req_t                lsu_req_i,
    input wire wb_pkg::wb_req_t                mul_req_i,
    input wire wb_pkg::wb_req_t                div_req_i,
    input wire wb_pkg::wb_req_t                csr_req_i,
    input wire wb_pkg::wb_req_t                alu_req_i,
    input wire                                 mul_ready_o,
    input wire                                 div_ready_o,
    input wire                                 csr_ready_o,
    input wire                                 alu_ready_o,
    input wire                                 issue_valid_i,
    input wire [wb_pkg::COMMIT_ID_WIDTH-1:0]   issue_id_i,
    input wire [wb_pkg::REG_ADDR_WIDTH-1:0]    raddr_a_i,
    input wire [wb_pkg::REG_ADDR_WIDTH-1:0]    raddr_b_i,
    input wire wb_pkg::wb_req_t                wb_o,
    input wire                                 commit_valid_o,
    input wire [wb_pkg::COMMIT_ID_WIDTH-1:0]   commit_id_o,
    input wire [wb_pkg::REG_DATA_WIDTH-1:0]    rdata_a_o,
    input wire [wb_pkg::REG_DATA_WIDTH-1:0]    rdata_b_o,
    input wire [wb_pkg::NUM_COMMIT_IDS-1:0]    pending_o
);

    import wb_pkg::*;

    int unsigned               err_cnt = 0;
    wb_req_t                   req  [NUM_SRCS];
    wb_req_t                   park [NUM_SRCS];
    wb_req_t                   sole;
    logic [NUM_SRCS-1:0]       rdy;
    logic [NUM_SRCS-1:0]       acc;
    logic [NUM_SRCS-1:0]       lose;
    logic                      fresh_only;
    logic [REG_DATA_WIDTH-1:0] shadow [2**REG_ADDR_WIDTH];

    assign req[SRC_LSU] = lsu_req_i;
    assign req[SRC_MUL] = mul_req_i;
    assign req[SRC_DIV] = div_req_i;
    assign req[SRC_CSR] = csr_req_i;
    assign req[SRC_ALU] = alu_req_i;
    assign rdy = {alu_ready_o, csr_ready_o, div_ready_o, mul_ready_o, 1'b1};

    // a request loses to lsu, any parked one or a higher fresh one
    always_comb begin
        lose = '0;
        for (int i = 0; i < NUM_SRCS; i++) begin
            acc[i] = req[i].we && rdy[i];
        end
        for (int i = int'(SRC_MUL); i < NUM_SRCS; i++) begin
            lose[i] = acc[i] && ((|(acc & ((NUM_SRCS'(1) << i) - 1'b1))) || !(&rdy));
        end
    end

    always_comb begin
        sole = '0;
        for (int i = 0; i < NUM_SRCS; i++) begin
            if (acc[i]) begin
                sole = req[i];
            end
        end
    end

    assign fresh_only = !acc[SRC_LSU] && (&rdy) && $onehot(acc);

    // expected content of a parked buffer
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SRCS; i++) begin
            if (lose[i]) begin
                park[i] <= req[i];
            end
        end
    end

    // reference register contents, x0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 2**REG_ADDR_WIDTH; k++) begin
                shadow[k] <= '0;
            end
        end else if (wb_o.we && (wb_o.waddr != '0)) begin
            shadow[wb_o.waddr] <= wb_o.wdata;
        end
    end

    a_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n))
        |-> !wb_o.we && !commit_valid_o && (&rdy))
        else begin err_cnt++; $error("MISMATCH %0t: outputs not idle around reset", $time); end

    a_lsu: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_req_i.we |=> wb_o == $past(lsu_req_i))
        else begin err_cnt++; $error("MISMATCH %0t: lsu write not forwarded", $time); end

    a_sole: assert property (@(posedge clk) disable iff (!rst_n)
        fresh_only |=> wb_o == $past(sole))
        else begin err_cnt++; $error("MISMATCH %0t: sole request not forwarded", $time); end

    for (genvar i = int'(SRC_MUL); i < NUM_SRCS; i++) begin : g_src
        a_stall: assert property (@(posedge clk) disable iff (!rst_n)
            lose[i] |=> !rdy[i])
            else begin err_cnt++; $error("MISMATCH %0t: source %0d not stalled", $time, i); end

        // ready comes back together with the parked write on wb_o
        a_drain: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(rdy[i]) |-> wb_o == park[i] && !$past(lsu_req_i.we))
            else begin err_cnt++; $error("MISMATCH %0t: source %0d bad drain", $time, i); end
    end

    a_rd_a: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_a_o == shadow[raddr_a_i])
        else begin err_cnt++; $error("MISMATCH %0t: read port a data", $time); end

    a_rd_b: assert property (@(posedge clk) disable iff (!rst_n)
        (rdata_b_o == shadow[raddr_b_i]) && ((raddr_b_i != '0) || (rdata_b_o == '0)))
        else begin err_cnt++; $error("MISMATCH %0t: read port b data", $time); end

    // commit port mirrors the strobe and tag of the registered write
    a_commit_port: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_valid_o == wb_o.we) && (commit_id_o == wb_o.commit_id))
        else begin err_cnt++; $error("MISMATCH %0t: commit port differs from wb_o", $time); end

    a_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid_i |=> pending_o[$past(issue_id_i)])
        else begin err_cnt++; $error("MISMATCH %0t: issued tag not pending", $time); end

    a_commit: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid_o && !(issue_valid_i && (issue_id_i == commit_id_o))
        |=> !pending_o[$past(commit_id_o)])
        else begin err_cnt++; $error("MISMATCH %0t: committed tag still pending", $time); end

endmodule

bind wb_top wb_top_properties u_props (.*);

`default_nettype wire
